//--- common/fix_pkg.sv
// FIX parser protocol definitions
// delimiter characters, the lane code reported by the delimiter search,
// and the structs carried along the word stream and kept in the field table
package fix_pkg;

	localparam logic [7:0] SOH_CHAR = 8'h01;
	localparam logic [7:0] EQ_CHAR  = 8'h3d;
	localparam logic [7:0] DIGIT_0  = 8'h30;

	// lane 0 is the first character of a word, bits 31:24
	typedef enum logic [2:0] {
		LANE_0    = 3'd0,
		LANE_1    = 3'd1,
		LANE_2    = 3'd2,
		LANE_3    = 3'd3,
		LANE_NONE = 3'd7
	} lane_e;

	typedef struct packed {
		logic [31:0] data;
		logic [2:0]  count;
	} fix_word_t;

	// tag and value bytes are left aligned, count gives the valid bytes
	typedef struct packed {
		logic [31:0] tag;
		logic [2:0]  tag_cnt;
		logic [31:0] value;
		logic [2:0]  value_cnt;
		logic        tag_valid;
		logic        value_valid;
		logic        tag_cont;
		logic        value_cont;
		logic        field_end;
		logic        spare;
	} frag_t;

	typedef struct packed {
		logic [15:0] tag_num;
		logic [7:0]  value_len;
		logic [7:0]  rsvd;
		logic [31:0] value_head;
	} field_rec_t;

endpackage

//--- common/bus_pkg.sv
// Wishbone classic bus definitions for the FIX parser
// request and response bundles plus the host address map
package bus_pkg;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [11:0] adr;
		logic [31:0] dat;
		logic [3:0]  sel;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic        err;
		logic [31:0] dat;
	} wb_rsp_t;

	// word push, write only
	localparam logic [11:0] ADDR_DATA  = 12'h000;

	// number of completed fields, read only
	localparam logic [11:0] ADDR_COUNT = 12'h004;

	// record k occupies TABLE_BASE + 8k and TABLE_BASE + 8k + 4
	localparam logic [11:0] TABLE_BASE = 12'h100;

endpackage

//--- design/delim_detect.sv
// Delimiter detector
// finds the first SOH and the first '=' among the valid characters of a
// pushed word and reports their byte lanes, or LANE_NONE when absent
`timescale 1ns/1ps

module delim_detect
	import fix_pkg::*;
(
	input  fix_word_t word_i,
	output lane_e     soh_lane_o,
	output lane_e     eq_lane_o
);

	logic [7:0] ch;

	always_comb begin
		soh_lane_o = LANE_NONE;
		eq_lane_o  = LANE_NONE;
		ch         = '0;
		// scan from the last lane down so the earliest match is kept
		for (int i = 3; i >= 0; i--) begin
			ch = word_i.data[31 - 8*i -: 8];
			if (i < int'(word_i.count)) begin
				if (ch == SOH_CHAR) begin
					soh_lane_o = lane_e'(3'(i));
				end
				if (ch == EQ_CHAR) begin
					eq_lane_o = lane_e'(3'(i));
				end
			end
		end
	end

endmodule

//--- design/field_extract.sv
// Field extractor
// splits one word into a tag fragment and a value fragment from the lanes
// of SOH and '=' and flags whether the tag or the value runs on into the
// next word. A word without delimiters goes wholly to the part named by
// the parse state. The result is registered for one cycle
`timescale 1ns/1ps

module field_extract
	import fix_pkg::*;
(
	input  logic      clk,
	input  logic      rst_i,
	input  logic      valid_i,
	input  fix_word_t word_i,
	input  lane_e     soh_lane_i,
	input  lane_e     eq_lane_i,
	input  logic      in_tag_i,
	input  logic      in_value_i,
	output frag_t     frag_o,
	output logic      frag_valid_o
);

	logic [2:0] s;
	logic [2:0] e;
	logic [2:0] n;
	frag_t      f;

	// bytes lo .. lo+cnt-1 moved to the top lanes, the rest cleared
	function automatic logic [31:0] take(input logic [31:0] d, input logic [2:0] lo,
		input logic [2:0] cnt);
		logic [31:0] mask;
		mask = ~(32'hffff_ffff >> {cnt, 3'b000});
		return (d << {lo, 3'b000}) & mask;
	endfunction

	always_comb begin
		s = soh_lane_i;
		e = eq_lane_i;
		n = word_i.count;
		f = '0;
		if (soh_lane_i != LANE_NONE && eq_lane_i != LANE_NONE) begin
			f.field_end = 1'b1;
			if (e < s) begin
				// the value between '=' and SOH closes the current field
				f.value     = take(word_i.data, e + 3'd1, s - e - 3'd1);
				f.value_cnt = s - e - 3'd1;
				if (e != 3'd0) begin
					f.tag     = take(word_i.data, 3'd0, e);
					f.tag_cnt = e;
				end else begin
					// bytes past the SOH open the next tag
					f.tag      = take(word_i.data, s + 3'd1, n - s - 3'd1);
					f.tag_cnt  = n - s - 3'd1;
					f.tag_cont = 1'b1;
				end
			end else begin
				// the next field's tag lies whole between SOH and '='
				f.tag     = take(word_i.data, s + 3'd1, e - s - 3'd1);
				f.tag_cnt = e - s - 3'd1;
				if (s != 3'd0) begin
					f.value     = take(word_i.data, 3'd0, s);
					f.value_cnt = s;
				end else begin
					f.value      = take(word_i.data, e + 3'd1, n - e - 3'd1);
					f.value_cnt  = n - e - 3'd1;
					f.value_cont = 1'b1;
				end
			end
		end else if (soh_lane_i != LANE_NONE) begin
			f.field_end = 1'b1;
			f.value     = take(word_i.data, 3'd0, s);
			f.value_cnt = s;
			f.tag       = take(word_i.data, s + 3'd1, n - s - 3'd1);
			f.tag_cnt   = n - s - 3'd1;
			f.tag_cont  = 1'b1;
		end else if (eq_lane_i != LANE_NONE) begin
			f.tag        = take(word_i.data, 3'd0, e);
			f.tag_cnt    = e;
			f.value      = take(word_i.data, e + 3'd1, n - e - 3'd1);
			f.value_cnt  = n - e - 3'd1;
			f.value_cont = 1'b1;
		end else if (in_tag_i) begin
			f.tag      = take(word_i.data, 3'd0, n);
			f.tag_cnt  = n;
			f.tag_cont = 1'b1;
		end else if (in_value_i) begin
			f.value      = take(word_i.data, 3'd0, n);
			f.value_cnt  = n;
			f.value_cont = 1'b1;
		end
		f.tag_valid   = (f.tag_cnt != 3'd0);
		f.value_valid = (f.value_cnt != 3'd0);
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			frag_valid_o <= 1'b0;
		end else begin
			frag_valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_i) begin
			frag_o <= f;
		end
	end

	// a word holds at most one of each delimiter, never in the same lane
	a_lanes_differ: assert property (@(posedge clk) disable iff (rst_i)
		valid_i |-> (soh_lane_i == LANE_NONE || soh_lane_i != eq_lane_i))
		else $error("SOH and '=' reported in the same lane");

endmodule

//--- design/field_assembler.sv
// Field assembler
// folds tag digits into a binary tag number, keeps the first four value
// bytes and a saturating value length. On SOH it writes the two-word
// record into the next table slot as a Wishbone classic master
`timescale 1ns/1ps

module field_assembler
	import fix_pkg::*;
	import bus_pkg::*;
#(
	parameter int TABLE_DEPTH   = 16,
	parameter int MAX_VALUE_LEN = 255
) (
	input  logic    clk,
	input  logic    rst_i,
	input  frag_t   frag_i,
	input  logic    frag_valid_i,
	output logic    ready_o,
	output logic    in_tag_o,
	output logic    in_value_o,
	output wb_req_t wb_o,
	input  wb_rsp_t wb_i
);

	localparam int SW = (TABLE_DEPTH > 1) ? $clog2(TABLE_DEPTH) : 1;

	logic          in_value_q;
	logic          busy_q;
	logic          phase_q;
	logic [SW-1:0] slot_q;
	logic [15:0]   tag_q;
	logic [7:0]    len_q;
	logic [31:0]   head_q;
	field_rec_t    rec_q;

	logic          pre_tag;
	logic          pre_val;
	logic [15:0]   cur_tag;
	logic [7:0]    cur_len;
	logic [31:0]   cur_head;

	function automatic logic [15:0] fold_tag(input logic [15:0] acc, input logic [31:0] b,
		input logic [2:0] cnt);
		logic [15:0] a;
		a = acc;
		for (int i = 0; i < 4; i++) begin
			if (i < int'(cnt)) begin
				a = a * 16'd10 + {8'd0, b[31 - 8*i -: 8] - DIGIT_0};
			end
		end
		return a;
	endfunction

	function automatic logic [31:0] fold_head(input logic [31:0] head, input logic [7:0] len,
		input logic [31:0] b, input logic [2:0] cnt);
		logic [31:0] h;
		int          pos;
		h = head;
		for (int i = 0; i < 4; i++) begin
			pos = int'(len) + i;
			if (i < int'(cnt) && pos < 4) begin
				h[31 - 8*pos -: 8] = b[31 - 8*i -: 8];
			end
		end
		return h;
	endfunction

	function automatic logic [7:0] fold_len(input logic [7:0] len, input logic [2:0] cnt);
		logic [8:0] sum;
		sum = {1'b0, len} + {6'd0, cnt};
		return (sum > 9'(MAX_VALUE_LEN)) ? 8'(MAX_VALUE_LEN) : sum[7:0];
	endfunction

	// on a closing word a tag belongs to the current field only when the
	// '=' came first, and a value only when it does not run on
	always_comb begin
		pre_tag  = !frag_i.field_end || (!in_value_q && !frag_i.tag_cont);
		pre_val  = !frag_i.field_end || !frag_i.value_cont;
		cur_tag  = tag_q;
		cur_len  = len_q;
		cur_head = head_q;
		if (frag_i.tag_valid && pre_tag) begin
			cur_tag = fold_tag(tag_q, frag_i.tag, frag_i.tag_cnt);
		end
		if (frag_i.value_valid && pre_val) begin
			cur_head = fold_head(head_q, len_q, frag_i.value, frag_i.value_cnt);
			cur_len  = fold_len(len_q, frag_i.value_cnt);
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			in_value_q <= 1'b0;
			busy_q     <= 1'b0;
			phase_q    <= 1'b0;
			slot_q     <= '0;
			tag_q      <= '0;
			len_q      <= '0;
			head_q     <= '0;
		end else if (busy_q) begin
			if (wb_i.ack) begin
				phase_q <= !phase_q;
				if (phase_q) begin
					busy_q <= 1'b0;
					slot_q <= (slot_q == SW'(TABLE_DEPTH - 1)) ? '0 : slot_q + 1'b1;
				end
			end
		end else if (frag_valid_i) begin
			if (frag_i.field_end) begin
				busy_q     <= 1'b1;
				// whatever follows the SOH starts the next field
				tag_q      <= (frag_i.tag_valid && !pre_tag) ?
					fold_tag('0, frag_i.tag, frag_i.tag_cnt) : '0;
				head_q     <= (frag_i.value_valid && !pre_val) ?
					fold_head('0, 8'd0, frag_i.value, frag_i.value_cnt) : '0;
				len_q      <= (frag_i.value_valid && !pre_val) ?
					fold_len(8'd0, frag_i.value_cnt) : '0;
				in_value_q <= in_value_q && frag_i.tag_valid && !frag_i.tag_cont;
			end else begin
				tag_q      <= cur_tag;
				len_q      <= cur_len;
				head_q     <= cur_head;
				in_value_q <= frag_i.value_cont;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy_q && frag_valid_i && frag_i.field_end) begin
			rec_q <= '{tag_num: cur_tag, value_len: cur_len, rsvd: 8'h00, value_head: cur_head};
		end
	end

	always_comb begin
		wb_o     = '0;
		wb_o.cyc = busy_q;
		wb_o.stb = busy_q;
		wb_o.we  = busy_q;
		wb_o.sel = 4'hf;
		wb_o.adr = TABLE_BASE + 12'({slot_q, phase_q, 2'b00});
		wb_o.dat = phase_q ? rec_q.value_head : {rec_q.tag_num, rec_q.value_len, rec_q.rsvd};
	end

	assign ready_o    = !busy_q && !(frag_valid_i && frag_i.field_end);
	assign in_tag_o   = !in_value_q;
	assign in_value_o = in_value_q;

	// the push ack that produced a fragment was granted two cycles earlier
	a_no_frag_when_busy: assert property (@(posedge clk) disable iff (rst_i)
		frag_valid_i |-> $past(ready_o, 2))
		else $error("fragment arrived while the assembler was not ready");

endmodule

//--- field_table/field_arbiter.sv
// Field table arbiter
// round-robin arbitration of two Wishbone classic masters onto the table
// store. A grant lasts for the whole cycle and only its owner sees ack
`timescale 1ns/1ps

module field_arbiter
	import bus_pkg::*;
(
	input  logic    clk,
	input  logic    rst_i,
	input  wb_req_t m0_req_i,
	input  wb_req_t m1_req_i,
	output wb_rsp_t m0_rsp_o,
	output wb_rsp_t m1_rsp_o,
	output wb_req_t s_req_o,
	input  wb_rsp_t s_rsp_i
);

	typedef enum logic [1:0] {
		IDLE,
		GRANT_M0,
		GRANT_M1
	} grant_e;

	grant_e state_q;
	logic   last_m1_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q   <= IDLE;
			last_m1_q <= 1'b1;
		end else begin
			case (state_q)
				IDLE: begin
					if (m0_req_i.cyc && (!m1_req_i.cyc || last_m1_q)) begin
						state_q <= GRANT_M0;
					end else if (m1_req_i.cyc) begin
						state_q <= GRANT_M1;
					end
				end
				GRANT_M0: begin
					if (!m0_req_i.cyc) begin
						state_q   <= IDLE;
						last_m1_q <= 1'b0;
					end
				end
				GRANT_M1: begin
					if (!m1_req_i.cyc) begin
						state_q   <= IDLE;
						last_m1_q <= 1'b1;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	always_comb begin
		s_req_o  = '0;
		m0_rsp_o = '0;
		m1_rsp_o = '0;
		case (state_q)
			GRANT_M0: begin
				s_req_o  = m0_req_i;
				m0_rsp_o = s_rsp_i;
			end
			GRANT_M1: begin
				s_req_o  = m1_req_i;
				m1_rsp_o = s_rsp_i;
			end
			default: ;
		endcase
	end

	// the store answers within the grant that issued the strobe
	a_ack_in_grant: assert property (@(posedge clk) disable iff (rst_i)
		s_rsp_i.ack |-> (state_q != IDLE && $past(state_q) == state_q))
		else $error("table ack outside the owning grant");

endmodule

//--- field_table/field_store.sv
// Field table store
// record memory and completed-field counter behind one Wishbone classic
// slave. Answers one cycle after strobe. The counter steps when the
// second word of a record is acknowledged
`timescale 1ns/1ps

module field_store
	import bus_pkg::*;
#(
	parameter int TABLE_DEPTH = 16
) (
	input  logic    clk,
	input  logic    rst_i,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	localparam int CW = (TABLE_DEPTH > 1) ? $clog2(TABLE_DEPTH) : 1;
	localparam int IW = CW + 1;

	logic [31:0]   mem [2*TABLE_DEPTH];
	logic [11:0]   off;
	logic [IW-1:0] idx;
	logic          hit;
	logic          ack_q;
	logic [31:0]   rd_q;
	logic [CW-1:0] count_q;

	assign hit = req_i.cyc && req_i.stb && !ack_q;
	assign off = req_i.adr - TABLE_BASE;
	assign idx = off[IW+1:2];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ack_q   <= 1'b0;
			count_q <= '0;
		end else begin
			ack_q <= hit;
			if (ack_q && req_i.we && req_i.adr[2]) begin
				count_q <= (count_q == CW'(TABLE_DEPTH - 1)) ? '0 : count_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (hit && req_i.we) begin
			mem[idx] <= req_i.dat;
		end
		if (hit && !req_i.we) begin
			rd_q <= (req_i.adr == ADDR_COUNT) ? 32'(count_q) : mem[idx];
		end
	end

	assign rsp_o = '{ack: ack_q, err: 1'b0, dat: rd_q};

endmodule

//--- design/fix_parser_top.sv
// FIX message parser top level
// decodes the host Wishbone port into word pushes and table reads,
// acks pushes with back-pressure from the assembler and errors unmapped
// accesses. Connects the data path and the shared field table
`timescale 1ns/1ps

module fix_parser_top
	import fix_pkg::*;
	import bus_pkg::*;
#(
	parameter int TABLE_DEPTH   = 16,
	parameter int MAX_VALUE_LEN = 255
) (
	input  logic    clk,
	input  logic    rst_i,
	input  wb_req_t host_req_i,
	output wb_rsp_t host_rsp_o
);

	logic      push_sel;
	logic      rd_sel;
	logic      bad_sel;
	logic      push_ack_q;
	logic      err_q;
	logic      ready;
	logic      in_tag;
	logic      in_value;
	fix_word_t word;
	lane_e     soh_lane;
	lane_e     eq_lane;
	frag_t     frag;
	logic      frag_valid;
	wb_req_t   asm_req;
	wb_req_t   rd_req;
	wb_req_t   store_req;
	wb_rsp_t   asm_rsp;
	wb_rsp_t   rd_rsp;
	wb_rsp_t   store_rsp;

	always_comb begin
		push_sel = host_req_i.cyc && host_req_i.stb && host_req_i.we
			&& host_req_i.adr == ADDR_DATA;
		rd_sel   = host_req_i.cyc && host_req_i.stb && !host_req_i.we
			&& (host_req_i.adr == ADDR_COUNT || host_req_i.adr >= TABLE_BASE);
		bad_sel  = host_req_i.cyc && host_req_i.stb && !push_sel && !rd_sel;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			push_ack_q <= 1'b0;
			err_q      <= 1'b0;
		end else begin
			// a push waits here while the assembler is writing a record
			push_ack_q <= push_sel && !push_ack_q && ready;
			err_q      <= bad_sel && !err_q;
		end
	end

	// sel is filled from the top lane down
	always_comb begin
		word.data  = host_req_i.dat;
		word.count = 3'(host_req_i.sel[3]) + 3'(host_req_i.sel[2])
			+ 3'(host_req_i.sel[1]) + 3'(host_req_i.sel[0]);
	end

	always_comb begin
		rd_req     = host_req_i;
		rd_req.cyc = rd_sel;
		rd_req.stb = rd_sel;
	end

	assign host_rsp_o = '{ack: push_ack_q || rd_rsp.ack, err: err_q, dat: rd_rsp.dat};

	delim_detect u_delim (
		.word_i     (word),
		.soh_lane_o (soh_lane),
		.eq_lane_o  (eq_lane)
	);

	field_extract u_extract (
		.clk          (clk),
		.rst_i        (rst_i),
		.valid_i      (push_ack_q),
		.word_i       (word),
		.soh_lane_i   (soh_lane),
		.eq_lane_i    (eq_lane),
		.in_tag_i     (in_tag),
		.in_value_i   (in_value),
		.frag_o       (frag),
		.frag_valid_o (frag_valid)
	);

	field_assembler #(
		.TABLE_DEPTH   (TABLE_DEPTH),
		.MAX_VALUE_LEN (MAX_VALUE_LEN)
	) u_assembler (
		.clk          (clk),
		.rst_i        (rst_i),
		.frag_i       (frag),
		.frag_valid_i (frag_valid),
		.ready_o      (ready),
		.in_tag_o     (in_tag),
		.in_value_o   (in_value),
		.wb_o         (asm_req),
		.wb_i         (asm_rsp)
	);

	field_arbiter u_arbiter (
		.clk      (clk),
		.rst_i    (rst_i),
		.m0_req_i (asm_req),
		.m1_req_i (rd_req),
		.m0_rsp_o (asm_rsp),
		.m1_rsp_o (rd_rsp),
		.s_req_o  (store_req),
		.s_rsp_i  (store_rsp)
	);

	field_store #(
		.TABLE_DEPTH (TABLE_DEPTH)
	) u_store (
		.clk   (clk),
		.rst_i (rst_i),
		.req_i (store_req),
		.rsp_o (store_rsp)
	);

endmodule

//--- bench/tb_fix_parser.sv
// Testbench for the FIX message parser
// pushes FIX text through the host Wishbone port, polls the field count
// until the expected fields are complete and compares every table record
// with a software model of field parsing. '|' in a test string stands for SOH
`timescale 1ns/1ps

module tb_fix_parser
	import fix_pkg::*;
	import bus_pkg::*;
();

	localparam int TABLE_DEPTH   = 16;
	localparam int MAX_VALUE_LEN = 255;
	localparam int CLK_NS        = 10;

	logic    clk;
	logic    rst_i;
	wb_req_t host_req;
	wb_rsp_t host_rsp;

	int          errors       = 0;
	int          checks       = 0;
	int          pushed_words = 0;
	int          done_fields  = 0;
	logic [31:0] model_w0 [$];
	logic [31:0] model_w1 [$];

	fix_parser_top #(
		.TABLE_DEPTH   (TABLE_DEPTH),
		.MAX_VALUE_LEN (MAX_VALUE_LEN)
	) UUT (
		.clk        (clk),
		.rst_i      (rst_i),
		.host_req_i (host_req),
		.host_rsp_o (host_rsp)
	);

	always #(CLK_NS / 2) clk = ~clk;

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// one classic transfer that starts and ends 1 ns after a rising edge
	task automatic bus_cycle(input logic we, input logic [11:0] adr, input logic [31:0] dat,
		input logic [3:0] sel, output logic [31:0] rdat, output logic err);
		host_req.cyc = 1'b1;
		host_req.stb = 1'b1;
		host_req.we  = we;
		host_req.adr = adr;
		host_req.dat = dat;
		host_req.sel = sel;
		do begin
			@(negedge clk);
		end while (!host_rsp.ack && !host_rsp.err);
		rdat = host_rsp.dat;
		err  = host_rsp.err;
		@(posedge clk);
		#1;
		host_req = '0;
	endtask

	task automatic wb_write(input logic [11:0] adr, input logic [31:0] dat, input logic [3:0] sel);
		logic [31:0] unused;
		logic        err;
		bus_cycle(1'b1, adr, dat, sel, unused, err);
		check({31'd0, err}, 32'd0, "err on word push");
	endtask

	// the idle cycle after a read lets the arbiter hand the table to the assembler
	task automatic wb_read(input logic [11:0] adr, output logic [31:0] dat, output logic err);
		bus_cycle(1'b0, adr, 32'd0, 4'hf, dat, err);
		@(posedge clk);
		#1;
	endtask

	function automatic void model_add(input string msg);
		logic [15:0] tag;
		logic [31:0] head;
		logic [7:0]  c;
		logic        in_value;
		int          len;
		tag      = '0;
		head     = '0;
		in_value = 1'b0;
		len      = 0;
		for (int i = 0; i < msg.len(); i++) begin
			c = msg[i];
			if (c == "|") begin
				model_w0.push_back({tag, 8'(len), 8'h00});
				model_w1.push_back(head);
				tag      = '0;
				head     = '0;
				in_value = 1'b0;
				len      = 0;
			end else if (!in_value && c == EQ_CHAR) begin
				in_value = 1'b1;
			end else if (!in_value) begin
				tag = tag * 16'd10 + {8'h00, c - 8'h30};
			end else begin
				if (len < 4) begin
					head[31 - 8*len -: 8] = c;
				end
				if (len < MAX_VALUE_LEN) begin
					len++;
				end
			end
		end
	endfunction

	task automatic expect_field(input int i);
		logic [31:0] d;
		logic        e;
		logic [11:0] base;
		base = TABLE_BASE + 12'(8 * (i % TABLE_DEPTH));
		wb_read(base, d, e);
		check(d, model_w0[i], $sformatf("record %0d tag and length", i));
		check({31'd0, e}, 32'd0, $sformatf("record %0d err on first word", i));
		wb_read(base + 12'd4, d, e);
		check(d, model_w1[i], $sformatf("record %0d value head", i));
		check({31'd0, e}, 32'd0, $sformatf("record %0d err on second word", i));
	endtask

	// with interleave set, a finished record is read back after every push
	task automatic send_message(input string msg, input bit interleave);
		logic [31:0] data;
		logic [3:0]  sel;
		int          n;
		for (int i = 0; i < msg.len(); i += 4) begin
			n    = (msg.len() - i < 4) ? msg.len() - i : 4;
			// lanes without a sel bit carry '=' that the parser has to ignore
			data = {4{EQ_CHAR}};
			sel  = '0;
			for (int j = 0; j < n; j++) begin
				data[31 - 8*j -: 8] = (msg[i+j] == "|") ? SOH_CHAR : msg[i+j];
				sel[3 - j]          = 1'b1;
			end
			wb_write(ADDR_DATA, data, sel);
			pushed_words++;
			if (interleave && done_fields > 0) begin
				expect_field(done_fields - 1);
			end
		end
	endtask

	task automatic settle_fields();
		logic [31:0] cnt;
		logic        e;
		int          target;
		int          polls;
		target = model_w0.size() % TABLE_DEPTH;
		polls  = 0;
		do begin
			wb_read(ADDR_COUNT, cnt, e);
			polls++;
		end while (cnt != 32'(target) && polls < 100);
		check(cnt, 32'(target), "field count");
		check({31'd0, e}, 32'd0, "err on count read");
		for (int i = done_fields; i < model_w0.size(); i++) begin
			expect_field(i);
		end
		done_fields = model_w0.size();
	endtask

	task automatic parse_and_verify(input string msg, input bit interleave);
		model_add(msg);
		send_message(msg, interleave);
		settle_fields();
	endtask

	task automatic reset_state();
		logic [31:0] d;
		logic        e;
		wb_read(ADDR_COUNT, d, e);
		check(d, 32'd0, "field count after reset");
		check({31'd0, e}, 32'd0, "err on count read");
		wb_read(12'h008, d, e);
		check({31'd0, e}, 32'd1, "err on unmapped read");
	endtask

	task automatic random_fields();
		string      msg;
		logic [7:0] c;
		int         nf;
		int         len;
		int         k;
		int         target;
		target = model_w0.size() + TABLE_DEPTH + 6;
		while (model_w0.size() < target) begin
			msg = "";
			nf  = $urandom_range(1, 4);
			for (int f = 0; f < nf; f++) begin
				msg = $sformatf("%s%0d=", msg, $urandom_range(1, 9999));
				len = $urandom_range(1, 12);
				for (int i = 0; i < len; i++) begin
					k   = $urandom_range(0, 35);
					c   = (k < 10) ? 8'h30 + 8'(k) : 8'h41 + 8'(k - 10);
					msg = $sformatf("%s%c", msg, c);
				end
				msg = {msg, "|"};
			end
			parse_and_verify(msg, 1'b1);
		end
	endtask

	// the limit grows with every pushed word
	initial begin
		while ($time <= 64'(CLK_NS) * 64'(2000 + 200 * pushed_words)) begin
			@(posedge clk);
		end
		$display("timeout: the parser stalled after %0d pushed words", pushed_words);
		$display("checks: %0d  errors: %0d", checks, errors + 1);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		void'($urandom(3));
		clk      = 1'b0;
		rst_i    = 1'b1;
		host_req = '0;
		repeat (16) @(posedge clk);
		#1;
		rst_i = 1'b0;

		reset_state();
		// every SOH and '=' lane pair appears in these two
		parse_and_verify("8=FIX.4.2|35=A|49=X|56=YZ|1=BC|", 1'b0);
		parse_and_verify("100=ABC|52=Q|", 1'b0);
		parse_and_verify("12345=ABCDEFGHIJ|7=HELLOWORLD|", 1'b0);
		parse_and_verify("58=THE QUICK BROWN FOX JUMPS OVER THE LAZY DOG|", 1'b0);
		parse_and_verify("55=IBM|", 1'b0);
		parse_and_verify("44=1|", 1'b0);
		parse_and_verify("58=OK|", 1'b0);
		random_fields();
		// each word holds one field so every push meets a busy assembler
		parse_and_verify("1=A|2=B|3=C|4=D|5=E|6=F|", 1'b0);
		parse_and_verify("11=AB|22=CD|333=XYZW|", 1'b0);

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
common/fix_pkg.sv
common/bus_pkg.sv
design/delim_detect.sv
design/field_extract.sv
design/field_assembler.sv
field_table/field_arbiter.sv
field_table/field_store.sv
design/fix_parser_top.sv
bench/tb_fix_parser.sv

//--- run.sh
#!/bin/sh
# build and run the FIX parser testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_fix_parser -f all.f -o sim_fix_parser
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_fix_parser > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" sim.log; then
	exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
	echo "no result line found in sim.log"
	exit 1
fi
exit 0
